// File: source/opd_pkg.sv
/*
 * Opcode decoder package.
 * Word and fill types, the length level, operation kind and trap code
 * encodings, and the fixed opcode words of the supported subset.
 */
package opd_pkg;

    typedef logic [15:0] word_t;  // Instruction or extension word.
    typedef logic [1:0]  fill_t;  // Queue fill count, 0 to 3.

    // Number of queue words an operation occupies.
    typedef enum logic [1:0] {
        LVL_D = 2'd0,  // One word.
        LVL_C = 2'd1,  // Two words.
        LVL_B = 2'd2   // Three words.
    } level_t;

    typedef enum logic [3:0] {
        OP_ORI, OP_ANDI, OP_SUBI, OP_ADDI, OP_EORI, OP_CMPI,
        OP_BCC, OP_MOVEQ, OP_NOP,
        OP_TRAP, OP_ILLEGAL, OP_STOP, OP_RTE,
        OP_UNIMPL
    } op_kind_t;

    typedef enum logic [2:0] {
        TRAP_NONE,
        TRAP_1010,     // A-line.
        TRAP_1111,     // F-line.
        TRAP_ILLEGAL,
        TRAP_TRAP,
        TRAP_PRIV      // Supervisor only operation in user mode.
    } trap_t;

    // Fixed opcode words.
    localparam word_t WORD_ILLEGAL = 16'h4AFC;
    localparam word_t WORD_NOP     = 16'h4E71;
    localparam word_t WORD_STOP    = 16'h4E72;
    localparam word_t WORD_RTE     = 16'h4E73;

    localparam logic [15:0] TRAP_VEC_BASE = 16'h4E40;  // TRAP #0, vector in bits 3:0.

endpackage

// File: source/opcode_fetch.sv
`timescale 1ns/1ns
/*
 * Opcode fetch controller.
 * Requests instruction words while the queue has room and drops
 * memory responses that belong to a request opened before a flush.
 */
module opcode_fetch (
    input  logic           CLK,
    input  logic           arst_n,
    input  logic           flush,
    input  opd_pkg::fill_t fill,
    input  logic           opcode_rdy,
    output logic           opcode_rd,
    output logic           word_take
);

    logic rd_q;     // Open read request.
    logic discard;  // Next response is stale.

    // The request is held until the memory answers. A flush or a pending
    // discard closes it so no new fetch starts before the old one returns.
    always_ff @(posedge CLK or negedge arst_n) begin : rd_ctrl
        if (!arst_n) begin
            rd_q <= 1'b0;
        end else if (opcode_rdy || discard || flush) begin
            rd_q <= 1'b0;
        end else if (fill < 2'd3) begin
            rd_q <= 1'b1;  // Room left in the queue.
        end
    end

    // Armed only when a request is really open, otherwise no response
    // would come to clear it.
    always_ff @(posedge CLK or negedge arst_n) begin : discard_ctrl
        if (!arst_n) begin
            discard <= 1'b0;
        end else if (flush && rd_q && !opcode_rdy) begin
            discard <= 1'b1;
        end else if (opcode_rdy) begin
            discard <= 1'b0;  // Stale word has arrived.
        end
    end

    assign opcode_rd = rd_q && !opcode_rdy;                 // Drop in the cycle of the answer.
    assign word_take = opcode_rdy && !discard && !flush;    // Same cycle flush also drops it.

endmodule

// File: source/prefetch_queue.sv
`timescale 1ns/1ns
/*
 * Three word instruction queue, stages D, C and B.
 * Pops one to three words toward stage D and appends the fetched word
 * behind the remaining ones. Every word carries its own fault bit.
 */
module prefetch_queue (
    input  logic              CLK,
    input  logic              arst_n,
    input  logic              flush,
    input  logic              word_take,
    input  opd_pkg::word_t    opcode_data,
    input  logic              opcode_valid,
    input  logic              pop_ops,
    input  logic              pop_ext,
    input  opd_pkg::level_t   level,
    output opd_pkg::word_t    stage_d,
    output opd_pkg::word_t    stage_c,
    output opd_pkg::word_t    stage_b,
    output logic              fault_d,
    output logic              fault_c,
    output logic              fault_b,
    output opd_pkg::fill_t    fill
);

    import opd_pkg::*;

    word_t      word_q [0:2];  // Index 0 is stage D.
    word_t      word_sh [0:2];
    logic [2:0] flt_q;
    logic [2:0] flt_sh;
    fill_t      fill_q;
    fill_t      pop_cnt;       // Words removed this cycle.
    fill_t      left;          // Words that stay.
    logic       take_ok;

    // ======================================
    // Pop count and free slot
    // ======================================
    always_comb begin : pop_count
        pop_cnt = 2'd0;
        if (pop_ops) begin
            case (level)
                LVL_D:   pop_cnt = 2'd1;
                LVL_C:   pop_cnt = 2'd2;
                default: pop_cnt = 2'd3;
            endcase
        end else if (pop_ext) begin
            pop_cnt = 2'd1;
        end
    end

    assign left    = fill_q - pop_cnt;
    assign take_ok = word_take && (left != 2'd3);  // Full and no pop drops the word.

    // ======================================
    // Shift toward D, then append
    // ======================================
    always_comb begin : shift_stage
        word_sh = word_q;
        flt_sh  = flt_q;
        case (pop_cnt)
            2'd1: begin
                word_sh[0] = word_q[1];
                word_sh[1] = word_q[2];
                flt_sh[0]  = flt_q[1];
                flt_sh[1]  = flt_q[2];
            end
            2'd2: begin
                word_sh[0] = word_q[2];
                flt_sh[0]  = flt_q[2];
            end
            default: ;  // Nothing kept or nothing moved.
        endcase
        if (take_ok) begin
            word_sh[left] = opcode_data;   // First free stage.
            flt_sh[left]  = ~opcode_valid;
        end
    end

    always_ff @(posedge CLK or negedge arst_n) begin : fill_reg
        if (!arst_n) begin
            fill_q <= 2'd0;
        end else if (flush) begin
            fill_q <= 2'd0;  // Queue emptied.
        end else begin
            fill_q <= left + fill_t'(take_ok);
        end
    end

    always_ff @(posedge CLK) begin : word_reg
        word_q <= word_sh;
        flt_q  <= flt_sh;
    end

    assign stage_d = word_q[0];
    assign stage_c = word_q[1];
    assign stage_b = word_q[2];
    assign fault_d = flt_q[0];
    assign fault_c = flt_q[1];
    assign fault_b = flt_q[2];
    assign fill    = fill_q;

endmodule

// File: source/opcode_classifier.sv
`timescale 1ns/1ns
/*
 * Opcode classifier.
 * Decodes the word in stage D into operation kind, length level and
 * trap code. Purely combinational.
 */
module opcode_classifier (
    input  opd_pkg::word_t    stage_d,
    input  logic              sbit,
    output opd_pkg::op_kind_t op_kind,
    output opd_pkg::level_t   level,
    output opd_pkg::trap_t    trap
);

    import opd_pkg::*;

    // ======================================
    // Operation kind
    // ======================================
    always_comb begin : kind_decode
        op_kind = OP_ILLEGAL;  // Anything not in the subset.
        case (stage_d[15:12])
            4'h0: begin
                if (stage_d[7:6] != 2'b11) begin  // Size 3 is not an immediate.
                    case (stage_d[11:9])
                        3'd0:    op_kind = OP_ORI;
                        3'd1:    op_kind = OP_ANDI;
                        3'd2:    op_kind = OP_SUBI;
                        3'd3:    op_kind = OP_ADDI;
                        3'd5:    op_kind = OP_EORI;
                        3'd6:    op_kind = OP_CMPI;
                        default: op_kind = OP_ILLEGAL;
                    endcase
                end
            end
            4'h4: begin
                if (stage_d[15:4] == TRAP_VEC_BASE[15:4]) begin
                    op_kind = OP_TRAP;  // 16 vectors.
                end else if (stage_d == WORD_ILLEGAL) begin
                    op_kind = OP_ILLEGAL;
                end else if (stage_d == WORD_NOP) begin
                    op_kind = OP_NOP;
                end else if (stage_d == WORD_STOP) begin
                    op_kind = OP_STOP;
                end else if (stage_d == WORD_RTE) begin
                    op_kind = OP_RTE;
                end
            end
            4'h6: op_kind = OP_BCC;
            4'h7: if (!stage_d[8]) op_kind = OP_MOVEQ;
            4'hA, 4'hF: op_kind = OP_UNIMPL;  // Line A and line F emulation.
            default: ;
        endcase
    end

    // ======================================
    // Trap code and length
    // ======================================
    always_comb begin : trap_decode
        trap = TRAP_NONE;
        case (op_kind)
            OP_UNIMPL:  trap = (stage_d[15:12] == 4'hA) ? TRAP_1010 : TRAP_1111;
            OP_ILLEGAL: trap = TRAP_ILLEGAL;
            OP_TRAP:    trap = TRAP_TRAP;
            OP_STOP, OP_RTE: if (!sbit) trap = TRAP_PRIV;  // User mode.
            default: ;
        endcase
    end

    always_comb begin : level_decode
        level = LVL_D;
        if (trap != TRAP_PRIV) begin  // Privileged stays on its first word.
            case (op_kind)
                OP_ORI, OP_ANDI, OP_SUBI, OP_ADDI, OP_EORI, OP_CMPI:
                    level = (stage_d[7:6] == 2'b10) ? LVL_B : LVL_C;  // Long needs two.
                OP_BCC: begin
                    if (stage_d[7:0] == 8'h00) begin
                        level = LVL_C;  // Word displacement.
                    end else if (stage_d[7:0] == 8'hFF) begin
                        level = LVL_B;  // Long displacement.
                    end
                end
                OP_STOP: level = LVL_C;  // Immediate status word.
                default: ;
            endcase
        end
    end

endmodule

// File: source/word_issue.sv
`timescale 1ns/1ns
/*
 * Issue stage.
 * Serves operation word and extension word requests from the queue,
 * pops the used words and registers the words, trap code and faults.
 */
module word_issue (
    input  logic              CLK,
    input  logic              arst_n,
    input  logic              flush,
    input  logic              ow_req,
    input  logic              ew_req,
    input  opd_pkg::word_t    stage_d,
    input  opd_pkg::word_t    stage_c,
    input  opd_pkg::word_t    stage_b,
    input  logic              fault_d,
    input  logic              fault_c,
    input  logic              fault_b,
    input  opd_pkg::fill_t    fill,
    input  opd_pkg::op_kind_t op_kind,
    input  opd_pkg::level_t   level,
    input  opd_pkg::trap_t    trap,
    output logic              pop_ops,
    output logic              pop_ext,
    output logic              ow_ack,
    output logic              ew_ack,
    output opd_pkg::op_kind_t op,
    output opd_pkg::word_t    biw_0,
    output opd_pkg::word_t    biw_1,
    output opd_pkg::word_t    biw_2,
    output opd_pkg::word_t    ext_word,
    output opd_pkg::trap_t    trap_code,
    output logic              ow_valid,
    output logic              fc,
    output logic              fb
);

    import opd_pkg::*;

    logic ops_ready;  // Operation present in full.

    // D and C are always needed to know the level, B only for level B.
    assign ops_ready = ow_req && (fill >= 2'd2) && (level != LVL_B || fill == 2'd3);
    assign pop_ops   = ops_ready && (trap != TRAP_PRIV) && !flush;
    assign pop_ext   = ew_req && (fill != 2'd0) && !flush;

    always_ff @(posedge CLK or negedge arst_n) begin : handshake
        if (!arst_n) begin
            ow_ack <= 1'b0;
            ew_ack <= 1'b0;
        end else begin
            ow_ack <= pop_ops;  // One cycle pulse.
            ew_ack <= pop_ext;
        end
    end

    // ======================================
    // Trap code and fault status
    // ======================================
    always_ff @(posedge CLK or negedge arst_n) begin : status_reg
        if (!arst_n) begin
            trap_code <= TRAP_NONE;
            ow_valid  <= 1'b0;
            fc        <= 1'b0;
            fb        <= 1'b0;
        end else if (flush) begin
            trap_code <= TRAP_NONE;
            ow_valid  <= 1'b0;
            fc        <= 1'b0;
            fb        <= 1'b0;
        end else if (ops_ready) begin
            trap_code <= trap;  // Also for a privileged operation.
            case (level)
                LVL_D: begin
                    ow_valid <= ~fault_d;
                    fc       <= 1'b0;
                    fb       <= 1'b0;
                end
                LVL_C: begin
                    ow_valid <= ~(fault_d | fault_c);
                    fc       <= fault_c;
                    fb       <= 1'b0;
                end
                default: begin
                    ow_valid <= ~(fault_d | fault_c | fault_b);
                    fc       <= fault_c;
                    fb       <= fault_b;
                end
            endcase
        end else if (pop_ext) begin
            ow_valid <= ~fault_d;  // Extension word fault.
            fc       <= 1'b0;
            fb       <= 1'b0;
        end
    end

    // Words stay visible for a privileged operation, needed for stacking.
    always_ff @(posedge CLK) begin : word_out
        if (ops_ready && !flush) begin
            op    <= op_kind;
            biw_0 <= stage_d;
            biw_1 <= stage_c;  // Meaningful for level C and B.
            biw_2 <= stage_b;  // Meaningful for level B.
        end
        if (pop_ext) begin
            ext_word <= stage_d;
        end
    end

endmodule

// File: source/opcode_decoder.sv
`timescale 1ns/1ns
/*
 * Instruction word decoder, first pipeline stage.
 * Fetch control, prefetch queue, classifier and issue stage.
 */
module opcode_decoder (
    input  logic              CLK,
    input  logic              arst_n,
    input  logic              flush,
    input  logic              sbit,
    input  logic              ow_req,
    input  logic              ew_req,
    input  logic              opcode_rdy,
    input  logic              opcode_valid,
    input  opd_pkg::word_t    opcode_data,
    output logic              opcode_rd,
    output logic              ow_ack,
    output logic              ew_ack,
    output opd_pkg::op_kind_t op,
    output opd_pkg::word_t    biw_0,
    output opd_pkg::word_t    biw_1,
    output opd_pkg::word_t    biw_2,
    output opd_pkg::word_t    ext_word,
    output opd_pkg::trap_t    trap_code,
    output logic              ow_valid,
    output logic              fc,
    output logic              fb
);

    import opd_pkg::*;

    logic     word_take;             // Fetched word enters the queue.
    logic     pop_ops;
    logic     pop_ext;
    word_t    stage_d;
    word_t    stage_c;
    word_t    stage_b;
    logic     fault_d;
    logic     fault_c;
    logic     fault_b;
    fill_t    fill;
    op_kind_t op_kind;               // Decode of stage D.
    level_t   level;
    trap_t    trap;

    opcode_fetch i_opcode_fetch (
        .CLK        (CLK),
        .arst_n     (arst_n),
        .flush      (flush),
        .fill       (fill),
        .opcode_rdy (opcode_rdy),
        .opcode_rd  (opcode_rd),
        .word_take  (word_take)
    );

    prefetch_queue i_prefetch_queue (
        .CLK          (CLK),
        .arst_n       (arst_n),
        .flush        (flush),
        .word_take    (word_take),
        .opcode_data  (opcode_data),
        .opcode_valid (opcode_valid),
        .pop_ops      (pop_ops),
        .pop_ext      (pop_ext),
        .level        (level),
        .stage_d      (stage_d),
        .stage_c      (stage_c),
        .stage_b      (stage_b),
        .fault_d      (fault_d),
        .fault_c      (fault_c),
        .fault_b      (fault_b),
        .fill         (fill)
    );

    opcode_classifier i_opcode_classifier (
        .stage_d (stage_d),
        .sbit    (sbit),
        .op_kind (op_kind),
        .level   (level),
        .trap    (trap)
    );

    word_issue i_word_issue (
        .CLK       (CLK),
        .arst_n    (arst_n),
        .flush     (flush),
        .ow_req    (ow_req),
        .ew_req    (ew_req),
        .stage_d   (stage_d),
        .stage_c   (stage_c),
        .stage_b   (stage_b),
        .fault_d   (fault_d),
        .fault_c   (fault_c),
        .fault_b   (fault_b),
        .fill      (fill),
        .op_kind   (op_kind),
        .level     (level),
        .trap      (trap),
        .pop_ops   (pop_ops),
        .pop_ext   (pop_ext),
        .ow_ack    (ow_ack),
        .ew_ack    (ew_ack),
        .op        (op),
        .biw_0     (biw_0),
        .biw_1     (biw_1),
        .biw_2     (biw_2),
        .ext_word  (ext_word),
        .trap_code (trap_code),
        .ow_valid  (ow_valid),
        .fc        (fc),
        .fb        (fb)
    );

endmodule

// File: tb/opcode_decoder_checker.sv
`timescale 1ns/1ns
/*
 * Protocol checker for the opcode decoder.
 * Acknowledge exclusion, acknowledge after request, fetch request hold.
 */
module opcode_decoder_checker (
    input logic CLK,
    input logic arst_n,
    input logic flush,
    input logic ow_req,
    input logic ew_req,
    input logic ow_ack,
    input logic ew_ack,
    input logic opcode_rd,
    input logic opcode_rdy
);

    // Only one kind of word is handed over per cycle.
    ack_exclusive : assert property (@(posedge CLK) disable iff (!arst_n)
        !(ow_ack && ew_ack)) else $error("ow_ack and ew_ack high together");

    ow_ack_after_req : assert property (@(posedge CLK) disable iff (!arst_n)
        ow_ack |-> $past(ow_req)) else $error("ow_ack without ow_req");

    ew_ack_after_req : assert property (@(posedge CLK) disable iff (!arst_n)
        ew_ack |-> $past(ew_req)) else $error("ew_ack without ew_req");

    // An open fetch ends only by an answer or a flush.
    rd_hold : assert property (@(posedge CLK) disable iff (!arst_n)
        (opcode_rd && !flush) |=> (opcode_rd || opcode_rdy || flush))
        else $error("opcode_rd dropped without opcode_rdy or flush");

endmodule

bind opcode_decoder opcode_decoder_checker i_opcode_decoder_checker (
    .CLK        (CLK),
    .arst_n     (arst_n),
    .flush      (flush),
    .ow_req     (ow_req),
    .ew_req     (ew_req),
    .ow_ack     (ow_ack),
    .ew_ack     (ew_ack),
    .opcode_rd  (opcode_rd),
    .opcode_rdy (opcode_rdy)
);

// File: tb/opcode_decoder_tb.sv
`timescale 1ns/1ns
/*
 * Testbench for the opcode decoder.
 * Memory model with random latency and faults, generated instruction
 * streams, reference decode and output comparison on each acknowledge.
 */
module opcode_decoder_tb;

    import opd_pkg::*;

    localparam int TIMEOUT = 200;  // Cycles per wait.

    logic CLK = 1'b0;
    logic arst_n, flush, sbit, ow_req, ew_req, opcode_rdy, opcode_valid;
    word_t opcode_data, biw_0, biw_1, biw_2, ext_word;
    logic opcode_rd, ow_ack, ew_ack, ow_valid, fc, fb;
    op_kind_t op;
    trap_t trap_code;

    word_t mem [0:1023];  // Instruction stream.
    bit    bad [0:1023];  // Word returned with opcode_valid low.
    int    rd_idx;        // Next stream word of the memory.
    int    exp_pos;       // Stream index the next acknowledge refers to.
    int    item_pos[$], item_words[$], item_ext[$];
    int    checks, errors;
    string test_name;

    opcode_decoder i_opcode_decoder (.*);

    always #4 CLK = ~CLK;  // 8 ns period.

    // ========================================
    // Reference decode
    // ========================================
    function automatic void ref_decode(input word_t w, input logic s, output op_kind_t k,
                                       output level_t l, output trap_t t);
        k = OP_ILLEGAL;
        l = LVL_D;
        t = TRAP_NONE;
        if (w[15:12] == 4'h0 && w[7:6] != 2'b11) begin
            if (w[11:9] == 3'd0) k = OP_ORI;
            if (w[11:9] == 3'd1) k = OP_ANDI;
            if (w[11:9] == 3'd2) k = OP_SUBI;
            if (w[11:9] == 3'd3) k = OP_ADDI;
            if (w[11:9] == 3'd5) k = OP_EORI;
            if (w[11:9] == 3'd6) k = OP_CMPI;
            if (k != OP_ILLEGAL) l = (w[7:6] == 2'b10) ? LVL_B : LVL_C;  // Long immediate.
        end else if (w[15:12] == 4'h6) begin
            k = OP_BCC;
            if (w[7:0] == 8'h00) l = LVL_C;
            if (w[7:0] == 8'hFF) l = LVL_B;
        end else if (w[15:12] == 4'h7 && !w[8]) begin
            k = OP_MOVEQ;
        end else if ((w & 16'hFFF0) == TRAP_VEC_BASE) begin
            k = OP_TRAP;
            t = TRAP_TRAP;
        end else if (w == WORD_NOP) begin
            k = OP_NOP;
        end else if (w == WORD_STOP || w == WORD_RTE) begin
            k = (w == WORD_STOP) ? OP_STOP : OP_RTE;
            if (w == WORD_STOP) l = LVL_C;  // Status word follows.
            if (!s) begin
                t = TRAP_PRIV;
                l = LVL_D;
            end
        end else if (w[15:12] == 4'hA || w[15:12] == 4'hF) begin
            k = OP_UNIMPL;
            t = (w[15:12] == 4'hA) ? TRAP_1010 : TRAP_1111;
        end
        if (k == OP_ILLEGAL) t = TRAP_ILLEGAL;
    endfunction

    function automatic word_t random_opcode();
        word_t w;
        w = word_t'($urandom);
        case ($urandom_range(0, 10))
            0:       w = {4'h0, 3'd0, 1'b0, 2'($urandom_range(0, 2)), w[5:0]};  // ORI.
            1:       w = {4'h0, 3'($urandom_range(1, 3)), 1'b0, 2'($urandom_range(0, 2)), w[5:0]};
            2:       w = {4'h0, 3'($urandom_range(5, 6)), 1'b0, 2'($urandom_range(0, 2)), w[5:0]};
            3:       w = {4'h6, w[11:8], ($urandom_range(0, 2) == 0) ? 8'hFF : w[7:0]};
            4:       w = {4'h7, w[11:9], 1'b0, w[7:0]};  // MOVEQ.
            5:       w = TRAP_VEC_BASE | {12'h000, w[3:0]};
            6:       w = ($urandom_range(0, 1) == 1) ? WORD_NOP : WORD_ILLEGAL;
            7:       w = ($urandom_range(0, 1) == 1) ? WORD_STOP : WORD_RTE;
            8:       w = {4'hA, w[11:0]};
            9:       w = {4'hF, w[11:0]};
            default: w = {4'h0, 3'd7, w[8:0]};  // Not in the subset.
        endcase
        return w;
    endfunction

    // One operation, its level words and zero to two extension words.
    task automatic place_item(input word_t opw, inout int pos);
        op_kind_t k;
        level_t   l;
        trap_t    t;
        int       n;
        ref_decode(opw, sbit, k, l, t);
        n = int'(l) + 1;
        item_pos.push_back(pos);
        item_words.push_back(n);
        item_ext.push_back($urandom_range(0, 2));
        mem[pos] = opw;
        for (int i = 0; i < n + item_ext[$] + 1; i++) begin
            if (i > 0) mem[pos + i] = word_t'($urandom);
            bad[pos + i] = ($urandom_range(0, 7) == 0);  // Roughly one word in eight faulty.
        end
        pos = pos + n + item_ext[$];
    endtask

    task automatic build_stream(input int start, input int count);
        int pos;
        pos = start;
        item_pos.delete();
        item_words.delete();
        item_ext.delete();
        for (int i = 0; i < count; i++) place_item(random_opcode(), pos);
    endtask

    // ========================================
    // Handshakes
    // ========================================
    task automatic request_word(input bit ops);
        int n;
        if (ops) ow_req = 1'b1;
        else ew_req = 1'b1;
        for (n = 0; n < TIMEOUT; n++) begin
            @(posedge CLK);
            #1;
            if ((ops && ow_ack) || (!ops && ew_ack)) break;
        end
        ow_req = 1'b0;  // Dropped in the acknowledge cycle.
        ew_req = 1'b0;
        if (n == TIMEOUT) begin
            $display("%s: timeout waiting for an acknowledge at index %0d", test_name, exp_pos);
            errors++;
        end
        @(posedge CLK);  // Compare runs on this edge.
        #1;
    endtask

    task automatic run_items();
        for (int i = 0; i < item_pos.size(); i++) begin
            exp_pos = item_pos[i];
            request_word(1'b1);
            for (int e = 0; e < item_ext[i]; e++) begin
                exp_pos = item_pos[i] + item_words[i] + e;
                request_word(1'b0);
            end
        end
    endtask

    task automatic flush_to(input int idx);
        rd_idx = idx;
        flush  = 1'b1;
        @(posedge CLK);
        #1 flush = 1'b0;
    endtask

    // A supervisor operation in user mode shows its trap and gets no acknowledge.
    task automatic expect_priv_trap(input word_t opw, input int idx);
        int n;
        mem[idx] = opw;
        bad[idx] = 1'b0;
        flush_to(idx);
        ow_req = 1'b1;
        for (n = 0; n < TIMEOUT && trap_code != TRAP_PRIV; n++) begin
            @(posedge CLK);
            #1;
        end
        if (n == TIMEOUT) begin
            $display("%s: trap_code never showed the privilege trap for %h", test_name, opw);
            errors++;
        end
        repeat (20) begin
            @(posedge CLK);
            #1;
            checks++;
            assert (!ow_ack) else begin
                $display("%s: privileged operation %h was acknowledged", test_name, opw);
                errors++;
            end
        end
        ow_req = 1'b0;
    endtask

    function automatic void check_value(input string what, input logic [15:0] exp,
                                        input logic [15:0] act);
        checks++;
        assert (exp === act) else begin
            $display("error %s: %s expected %h actual %h", test_name, what, exp, act);
            errors++;
        end
    endfunction

    // ========================================
    // Comparison
    // ========================================
    always @(posedge CLK) begin : compare_outputs
        op_kind_t k;
        level_t   l;
        trap_t    t;
        if (arst_n && ow_ack) begin
            ref_decode(mem[exp_pos], sbit, k, l, t);
            check_value("op", 16'(k), 16'(op));
            check_value("trap_code", 16'(t), 16'(trap_code));
            check_value("biw_0", mem[exp_pos], biw_0);
            if (l != LVL_D) check_value("biw_1", mem[exp_pos + 1], biw_1);
            if (l == LVL_B) check_value("biw_2", mem[exp_pos + 2], biw_2);
            check_value("ow_valid", 16'(!(bad[exp_pos] || (l != LVL_D && bad[exp_pos + 1])
                        || (l == LVL_B && bad[exp_pos + 2]))), 16'(ow_valid));
            check_value("fc", 16'(l != LVL_D && bad[exp_pos + 1]), 16'(fc));
            check_value("fb", 16'(l == LVL_B && bad[exp_pos + 2]), 16'(fb));
        end
        if (arst_n && ew_ack) begin
            check_value("ext_word", mem[exp_pos], ext_word);
            check_value("ow_valid", 16'(!bad[exp_pos]), 16'(ow_valid));  // Extension fault.
        end
    end

    // Answers each fetch after 1 to 4 cycles, stale after a flush.
    initial begin : memory_model
        int delay;
        bit stale;
        opcode_rdy   = 1'b0;
        opcode_valid = 1'b0;
        opcode_data  = '0;
        forever begin
            @(posedge CLK);
            if (arst_n && opcode_rd) begin
                delay = $urandom_range(1, 4);
                stale = flush;
                repeat (delay - 1) begin
                    @(posedge CLK);
                    if (flush) stale = 1'b1;
                end
                #1;
                opcode_rdy   = 1'b1;
                opcode_data  = mem[rd_idx];
                opcode_valid = !bad[rd_idx];
                @(posedge CLK);
                if (flush) stale = 1'b1;
                if (!stale) rd_idx++;  // Stream moves only on a delivered word.
                #1;
                opcode_rdy  = 1'b0;
                opcode_data = word_t'($urandom);
            end
        end
    end

    // ========================================
    // Stimulus
    // ========================================
    initial begin : stimulus
        int n;
        int pos;
        void'($urandom(32'hebf0_f681));
        arst_n = 1'b0;
        flush  = 1'b0;
        sbit   = 1'b1;
        ow_req = 1'b0;
        ew_req = 1'b0;
        rd_idx = 0;
        checks = 0;
        errors = 0;
        for (int a = 0; a < 1024; a++) begin
            mem[a] = word_t'(a * 16'h9E37);  // Odd multiplier, unique per address.
            bad[a] = 1'b0;
        end
        pos = 0;
        // Every immediate size and Bcc displacement form first.
        place_item(16'h0000, pos);
        place_item(16'h0240, pos);
        place_item(16'h0480, pos);
        place_item(16'h6600, pos);
        place_item(16'h67FF, pos);
        place_item(16'h6012, pos);
        for (int i = 0; i < 40; i++) place_item(random_opcode(), pos);
        repeat (8) @(posedge CLK);
        #1 arst_n = 1'b1;

        test_name = "sequential";
        run_items();

        // Privileged STOP and RTE in user mode are never acknowledged.
        test_name = "privilege";
        sbit = 1'b0;
        expect_priv_trap(WORD_STOP, 600);
        expect_priv_trap(WORD_RTE, 650);
        sbit   = 1'b1;
        pos = 700;
        item_pos.delete();
        item_words.delete();
        item_ext.delete();
        place_item(WORD_STOP, pos);
        place_item(WORD_RTE, pos);
        for (int i = 0; i < 20; i++) place_item(random_opcode(), pos);
        flush_to(700);
        test_name = "resume";
        run_items();

        // Flush while a fetch is open.
        test_name = "flush_in_flight";
        build_stream(400, 20);
        flush_to(300);
        for (n = 0; n < TIMEOUT; n++) begin
            @(posedge CLK);
            if (opcode_rd) break;
        end
        if (n == TIMEOUT) begin
            $display("%s: no fetch request after flush", test_name);
            errors++;
        end
        #1 flush_to(400);
        run_items();

        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: opcode_decoder.f
source/opd_pkg.sv
source/opcode_fetch.sv
source/prefetch_queue.sv
source/opcode_classifier.sv
source/word_issue.sv
source/opcode_decoder.sv
tb/opcode_decoder_checker.sv
tb/opcode_decoder_tb.sv

// File: Makefile
# Verilator build and run of the opcode decoder testbench.
TOP = opcode_decoder_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   list the targets"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f opcode_decoder.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee /dev/stderr | grep -q "RESULT: PASS"

clean:
	rm -rf obj_dir
